// File: hw/spi_pkg.sv
/* Shared types and constants for the SPI master.
   QUEUE_DEPTH must be a power of two since the queue pointers wrap freely.
   Frames are fixed at FRAME_BITS, MSB first, on a single data lane. */

`default_nettype none

package spi_pkg;

  // ------------------------------------------------------------------------
  // sizes
  // ------------------------------------------------------------------------
  localparam int NUM_CS         = 4;
  localparam int FRAME_BITS     = 8;
  localparam int QUEUE_DEPTH    = 4;
  localparam int AXIL_ADDR_BITS = 4;

  localparam int CS_SEL_BITS    = $clog2(NUM_CS);
  localparam int QUEUE_PTR_BITS = $clog2(QUEUE_DEPTH);
  localparam int QUEUE_CNT_BITS = $clog2(QUEUE_DEPTH + 1);
  // two spi_clk edges per bit
  localparam int EDGE_BITS      = $clog2(2 * FRAME_BITS);

  // axi response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // CTRL fields: cpol, cpha, clk_div byte, cs_sel in byte lane 2
  localparam int CTRL_CPOL_BIT = 0;
  localparam int CTRL_CPHA_BIT = 1;
  localparam int CTRL_DIV_LSB  = 8;
  localparam int CTRL_CS_LSB   = 16;
  // RXDATA keeps the byte low and the source chip select in lane 2
  localparam int RX_CS_LSB     = 16;
  // STATUS flags
  localparam int STAT_BUSY_BIT = 0;
  localparam int STAT_RXV_BIT  = 1;
  localparam int STAT_OVR_BIT  = 2;

  // ------------------------------------------------------------------------
  // enums
  // ------------------------------------------------------------------------
  typedef enum logic [AXIL_ADDR_BITS-1:0] {
    REG_CTRL   = 4'h0,
    REG_TXDATA = 4'h4,
    REG_RXDATA = 4'h8,
    REG_STATUS = 4'hC
  } reg_addr_e;

  typedef enum logic [1:0] {
    ENG_IDLE,
    ENG_SETUP,
    ENG_SHIFT,
    ENG_HOLD
  } eng_state_e;

  // ------------------------------------------------------------------------
  // structs
  // ------------------------------------------------------------------------
  // settings snapshot taken at the TXDATA write
  typedef struct packed {
    logic                   cpol;
    logic                   cpha;
    logic [7:0]             clk_div;
    logic [CS_SEL_BITS-1:0] cs_sel;
  } spi_cfg_t;

  typedef struct packed {
    spi_cfg_t              cfg;
    logic [FRAME_BITS-1:0] data;
  } spi_cmd_t;

  typedef struct packed {
    logic [FRAME_BITS-1:0]  data;
    logic [CS_SEL_BITS-1:0] cs_sel;
  } spi_rx_t;

  // host to slave channels
  typedef struct packed {
    logic                      awvalid;
    logic [AXIL_ADDR_BITS-1:0] awaddr;
    logic                      wvalid;
    logic [31:0]               wdata;
    logic [3:0]                wstrb;
    logic                      bready;
    logic                      arvalid;
    logic [AXIL_ADDR_BITS-1:0] araddr;
    logic                      rready;
  } axil_req_t;

  // slave to host channels
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axil_rsp_t;

endpackage

`default_nettype wire

// File: hw/spi_axil_regs.sv
/* AXI4-Lite register front end. One outstanding transaction at a time,
   writes take priority over reads in the same cycle. A TXDATA write to a
   full queue gets SLVERR and the byte is lost. RXDATA is invalid before
   the first frame completes. */

`default_nettype none

module spi_axil_regs
  import spi_pkg::*;
(
  input  logic      sclk,
  input  logic      arst_n,
  input  axil_req_t axil_req,
  output axil_rsp_t axil_rsp,
  output logic      cmd_valid,
  input  logic      cmd_ready,
  output spi_cmd_t  cmd,
  input  logic      rx_valid,
  input  spi_rx_t   rx,
  input  logic      engine_busy
);

  // response channel state
  logic        bvalid_q;
  logic [1:0]  bresp_q;
  logic        rvalid_q;
  logic [31:0] rdata_q;
  logic [1:0]  rresp_q;

  // register contents
  spi_cfg_t    ctrl_q;
  spi_rx_t     rx_q;
  logic        rx_valid_q;
  logic        rx_overrun_q;

  logic        wr_fire;
  logic        rd_fire;
  reg_addr_e   waddr;
  reg_addr_e   raddr;
  logic [1:0]  wr_resp;
  logic [1:0]  rd_resp;
  logic [31:0] rd_word;
  logic        rxdata_read;
  logic        status_read;

  // ------------------------------------------------------------------------
  // handshakes
  // ------------------------------------------------------------------------
  // both address and data must be present, nothing new while a response waits
  assign wr_fire = axil_req.awvalid && axil_req.wvalid && !bvalid_q && !rvalid_q;
  assign rd_fire = axil_req.arvalid && !wr_fire && !bvalid_q && !rvalid_q;

  assign waddr = reg_addr_e'(axil_req.awaddr);
  assign raddr = reg_addr_e'(axil_req.araddr);

  assign rxdata_read = rd_fire && (raddr == REG_RXDATA);
  assign status_read = rd_fire && (raddr == REG_STATUS);

  // frame = current control snapshot plus the written byte
  assign cmd.cfg  = ctrl_q;
  assign cmd.data = axil_req.wdata[FRAME_BITS-1:0];

  // write decode, RXDATA and STATUS writes are ignored
  always_comb begin
    wr_resp   = RESP_OKAY;
    cmd_valid = 1'b0;
    case (waddr)
      REG_CTRL, REG_RXDATA, REG_STATUS: wr_resp = RESP_OKAY;
      REG_TXDATA: begin
        cmd_valid = wr_fire;
        // queue full, drop the byte
        if (!cmd_ready) wr_resp = RESP_SLVERR;
      end
      default: wr_resp = RESP_SLVERR;
    endcase
  end

  // read mux
  always_comb begin
    rd_word = '0;
    rd_resp = RESP_OKAY;
    case (raddr)
      REG_CTRL: begin
        rd_word[CTRL_CPOL_BIT]                 = ctrl_q.cpol;
        rd_word[CTRL_CPHA_BIT]                 = ctrl_q.cpha;
        rd_word[CTRL_DIV_LSB +: 8]             = ctrl_q.clk_div;
        rd_word[CTRL_CS_LSB +: CS_SEL_BITS]    = ctrl_q.cs_sel;
      end
      // write only, reads as zero
      REG_TXDATA: rd_word = '0;
      REG_RXDATA: begin
        rd_word[FRAME_BITS-1:0]                = rx_q.data;
        rd_word[RX_CS_LSB +: CS_SEL_BITS]      = rx_q.cs_sel;
      end
      REG_STATUS: begin
        // queue backed up counts as busy too
        rd_word[STAT_BUSY_BIT] = engine_busy || !cmd_ready;
        rd_word[STAT_RXV_BIT]  = rx_valid_q;
        rd_word[STAT_OVR_BIT]  = rx_overrun_q;
      end
      default: rd_resp = RESP_SLVERR;
    endcase
  end

  // ------------------------------------------------------------------------
  // control state
  // ------------------------------------------------------------------------
  always_ff @(posedge sclk or negedge arst_n) begin
    if (!arst_n) begin
      bvalid_q     <= 1'b0;
      rvalid_q     <= 1'b0;
      ctrl_q       <= '0;
      rx_valid_q   <= 1'b0;
      rx_overrun_q <= 1'b0;
    end else begin
      if (wr_fire) bvalid_q <= 1'b1;
      else if (axil_req.bready) bvalid_q <= 1'b0;

      if (rd_fire) rvalid_q <= 1'b1;
      else if (axil_req.rready) rvalid_q <= 1'b0;

      // per byte lane update of CTRL
      if (wr_fire && (waddr == REG_CTRL)) begin
        if (axil_req.wstrb[0]) begin
          ctrl_q.cpol <= axil_req.wdata[CTRL_CPOL_BIT];
          ctrl_q.cpha <= axil_req.wdata[CTRL_CPHA_BIT];
        end
        if (axil_req.wstrb[1]) ctrl_q.clk_div <= axil_req.wdata[CTRL_DIV_LSB +: 8];
        if (axil_req.wstrb[2]) ctrl_q.cs_sel <= axil_req.wdata[CTRL_CS_LSB +: CS_SEL_BITS];
      end

      if (rxdata_read) rx_valid_q <= 1'b0;
      if (status_read) rx_overrun_q <= 1'b0;

      // a new frame wins over a clear in the same cycle
      if (rx_valid) begin
        rx_valid_q <= 1'b1;
        if (rx_valid_q && !rxdata_read) rx_overrun_q <= 1'b1;
      end
    end
  end

  // payload, only meaningful when qualified by its valid
  always_ff @(posedge sclk) begin
    if (wr_fire) bresp_q <= wr_resp;
    if (rd_fire) begin
      rdata_q <= rd_word;
      rresp_q <= rd_resp;
    end
    if (rx_valid) rx_q <= rx;
  end

  always_comb begin
    axil_rsp.awready = wr_fire;
    axil_rsp.wready  = wr_fire;
    axil_rsp.bvalid  = bvalid_q;
    axil_rsp.bresp   = bresp_q;
    axil_rsp.arready = rd_fire;
    axil_rsp.rvalid  = rvalid_q;
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = rresp_q;
  end

endmodule

`default_nettype wire

// File: hw/spi_cmd_queue.sv
/* Command FIFO, QUEUE_DEPTH entries, first word visible one cycle after
   its push. When full it still takes a push in a cycle that also pops. */

`default_nettype none

module spi_cmd_queue
  import spi_pkg::*;
(
  input  logic     sclk,
  input  logic     arst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  spi_cmd_t in_cmd,
  output logic     out_valid,
  input  logic     out_ready,
  output spi_cmd_t out_cmd
);

  spi_cmd_t                  mem_q [QUEUE_DEPTH];
  logic [QUEUE_PTR_BITS-1:0] wr_ptr_q;
  logic [QUEUE_PTR_BITS-1:0] rd_ptr_q;
  logic [QUEUE_CNT_BITS-1:0] count_q;
  logic                      full;
  logic                      push;
  logic                      pop;

  // status from the count alone
  assign full      = (count_q == QUEUE_CNT_BITS'(QUEUE_DEPTH));
  assign out_valid = (count_q != '0);
  // room appears if the head leaves this cycle
  assign in_ready  = !full || out_ready;

  assign push    = in_valid && in_ready;
  assign pop     = out_valid && out_ready;
  assign out_cmd = mem_q[rd_ptr_q];

  // pointers wrap by overflow
  always_ff @(posedge sclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (push && !pop) count_q <= count_q + 1'b1;
      else if (pop && !push) count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge sclk) begin
    if (push) mem_q[wr_ptr_q] <= in_cmd;
  end

endmodule

`default_nettype wire

// File: hw/spi_shift_engine.sv
/* SPI shift engine, one 8-bit frame at a time, MSB first, single lane.
   Half-period is clk_div+1 sclk cycles. miso is sampled directly on sclk,
   so the slave must hold it stable around the sampling edge. */

`default_nettype none

module spi_shift_engine
  import spi_pkg::*;
(
  input  logic              sclk,
  input  logic              arst_n,
  input  logic              cmd_valid,
  output logic              cmd_ready,
  input  spi_cmd_t          cmd,
  output logic              rx_valid,
  output spi_rx_t           rx,
  output logic              busy,
  output logic              spi_clk,
  output logic              mosi,
  output logic [NUM_CS-1:0] cs_n,
  input  logic              miso
);

  eng_state_e             state_q;
  spi_cfg_t               cfg_q;
  logic [7:0]             half_cnt_q;
  logic [EDGE_BITS-1:0]   edge_cnt_q;
  logic [FRAME_BITS-1:0]  tx_sr_q;
  logic [FRAME_BITS-1:0]  rx_sr_q;
  logic                   spi_clk_q;
  logic                   mosi_q;
  logic [NUM_CS-1:0]      cs_n_q;
  logic                   rx_valid_q;

  logic                   accept;
  logic                   tick;
  logic                   do_edge;
  logic                   leading;
  logic                   sample_edge;

  // ------------------------------------------------------------------------
  // edge timing
  // ------------------------------------------------------------------------
  assign cmd_ready = (state_q == ENG_IDLE);
  assign busy      = (state_q != ENG_IDLE);
  assign accept    = cmd_valid && cmd_ready;

  // end of a half-period
  assign tick = (half_cnt_q == cfg_q.clk_div);

  // first edge leaves SETUP, the other fifteen happen in SHIFT
  assign do_edge = tick && ((state_q == ENG_SETUP) || (state_q == ENG_SHIFT));

  // even edge count is the leading edge of a bit
  assign leading = !edge_cnt_q[0];

  // cpha 0 samples on leading, cpha 1 on trailing
  assign sample_edge = leading ^ cfg_q.cpha;

  // ------------------------------------------------------------------------
  // state machine and pins
  // ------------------------------------------------------------------------
  always_ff @(posedge sclk or negedge arst_n) begin
    if (!arst_n) begin
      state_q    <= ENG_IDLE;
      cfg_q      <= '0;
      half_cnt_q <= '0;
      edge_cnt_q <= '0;
      spi_clk_q  <= 1'b0;
      mosi_q     <= 1'b0;
      cs_n_q     <= '1;
      rx_valid_q <= 1'b0;
    end else begin
      rx_valid_q <= 1'b0;

      if (state_q == ENG_IDLE) half_cnt_q <= '0;
      else if (tick) half_cnt_q <= '0;
      else half_cnt_q <= half_cnt_q + 1'b1;

      if (do_edge) begin
        spi_clk_q  <= !spi_clk_q;
        edge_cnt_q <= edge_cnt_q + 1'b1;
        if (!sample_edge) mosi_q <= tx_sr_q[FRAME_BITS-1];
      end

      case (state_q)
        ENG_IDLE: begin
          if (accept) begin
            state_q    <= ENG_SETUP;
            cfg_q      <= cmd.cfg;
            edge_cnt_q <= '0;
            // idle level of the new frame
            spi_clk_q  <= cmd.cfg.cpol;
            cs_n_q     <= ~(NUM_CS'(1) << cmd.cfg.cs_sel);
            // cpha 0 needs the msb out before the first edge
            if (!cmd.cfg.cpha) mosi_q <= cmd.data[FRAME_BITS-1];
          end
        end
        ENG_SETUP: begin
          if (tick) state_q <= ENG_SHIFT;
        end
        ENG_SHIFT: begin
          if (tick && (edge_cnt_q == EDGE_BITS'(2 * FRAME_BITS - 1))) state_q <= ENG_HOLD;
        end
        ENG_HOLD: begin
          // release select and hand the byte back
          if (tick) begin
            state_q    <= ENG_IDLE;
            cs_n_q     <= '1;
            rx_valid_q <= 1'b1;
          end
        end
        default: state_q <= ENG_IDLE;
      endcase
    end
  end

  // shift registers
  always_ff @(posedge sclk) begin
    if (accept) begin
      // cpha 0 already put the msb out, so skip it
      if (cmd.cfg.cpha) tx_sr_q <= cmd.data;
      else tx_sr_q <= {cmd.data[FRAME_BITS-2:0], 1'b0};
    end else if (do_edge && !sample_edge) begin
      tx_sr_q <= {tx_sr_q[FRAME_BITS-2:0], 1'b0};
    end

    if (do_edge && sample_edge) rx_sr_q <= {rx_sr_q[FRAME_BITS-2:0], miso};
  end

  assign spi_clk   = spi_clk_q;
  assign mosi      = mosi_q;
  assign cs_n      = cs_n_q;
  assign rx_valid  = rx_valid_q;
  assign rx.data   = rx_sr_q;
  assign rx.cs_sel = cfg_q.cs_sel;

endmodule

`default_nettype wire

// File: hw/spi_master_top.sv
/* SPI master with AXI4-Lite host port. Register block feeds a command
   queue, which feeds the shift engine. Single lane, 8-bit frames only. */

`default_nettype none

module spi_master_top
  import spi_pkg::*;
(
  input  logic              sclk,
  input  logic              arst_n,
  input  axil_req_t         axil_req,
  output axil_rsp_t         axil_rsp,
  output logic              spi_clk,
  output logic              mosi,
  output logic [NUM_CS-1:0] cs_n,
  input  logic              miso
);

  // registers to queue
  logic     reg_cmd_valid;
  logic     reg_cmd_ready;
  spi_cmd_t reg_cmd;

  // queue to engine
  logic     eng_cmd_valid;
  logic     eng_cmd_ready;
  spi_cmd_t eng_cmd;

  // engine back to registers
  logic     rx_valid;
  spi_rx_t  rx;
  logic     engine_busy;

  spi_axil_regs u_regs (
    .sclk        (sclk),
    .arst_n      (arst_n),
    .axil_req    (axil_req),
    .axil_rsp    (axil_rsp),
    .cmd_valid   (reg_cmd_valid),
    .cmd_ready   (reg_cmd_ready),
    .cmd         (reg_cmd),
    .rx_valid    (rx_valid),
    .rx          (rx),
    .engine_busy (engine_busy)
  );

  spi_cmd_queue u_queue (
    .sclk      (sclk),
    .arst_n    (arst_n),
    .in_valid  (reg_cmd_valid),
    .in_ready  (reg_cmd_ready),
    .in_cmd    (reg_cmd),
    .out_valid (eng_cmd_valid),
    .out_ready (eng_cmd_ready),
    .out_cmd   (eng_cmd)
  );

  spi_shift_engine u_engine (
    .sclk      (sclk),
    .arst_n    (arst_n),
    .cmd_valid (eng_cmd_valid),
    .cmd_ready (eng_cmd_ready),
    .cmd       (eng_cmd),
    .rx_valid  (rx_valid),
    .rx        (rx),
    .busy      (engine_busy),
    .spi_clk   (spi_clk),
    .mosi      (mosi),
    .cs_n      (cs_n),
    .miso      (miso)
  );

endmodule

`default_nettype wire

// File: bench/spi_master_checker.sv
/* SVA on the SPI pins of the shift engine, attached with bind.
   Assumes a single active chip select per frame and MSB-first frames. */

`default_nettype none

module spi_master_checker
  import spi_pkg::*;
(
  input logic              sclk,
  input logic              arst_n,
  input logic [NUM_CS-1:0] cs_n,
  input logic              spi_clk,
  input logic              mosi,
  input logic              cpol,
  input logic              cpha
);

  // ------------------------------------------------------------------------
  // chip select
  // ------------------------------------------------------------------------
  // never more than one slave selected
  a_cs_onehot0: assert property (@(posedge sclk) disable iff (!arst_n)
    $onehot0(~cs_n))
    else $error("more than one cs_n line low");

  a_cs_after_reset: assert property (@(posedge sclk) $rose(arst_n) |-> (&cs_n))
    else $error("cs_n not all ones after reset");

  // ------------------------------------------------------------------------
  // clock and data
  // ------------------------------------------------------------------------
  // idle clock level follows the latched cpol
  a_idle_clk: assert property (@(posedge sclk) disable iff (!arst_n)
    (&cs_n) |-> (spi_clk == cpol))
    else $error("spi_clk not at cpol while deselected");

  // sampling edge seen on the pins: leading for cpha 0, trailing for cpha 1
  // leading leaves spi_clk away from cpol, trailing brings it back
  a_mosi_stable: assert property (@(posedge sclk) disable iff (!arst_n)
    (!(&cs_n) && (spi_clk != $past(spi_clk)) && (spi_clk ^ cpol ^ cpha))
      |-> (mosi == $past(mosi)))
    else $error("mosi changed on a sampling edge");

endmodule

bind spi_shift_engine spi_master_checker u_checker (
  .sclk    (sclk),
  .arst_n  (arst_n),
  .cs_n    (cs_n),
  .spi_clk (spi_clk),
  .mosi    (mosi),
  .cpol    (cfg_q.cpol),
  .cpha    (cfg_q.cpha)
);

`default_nettype wire

// File: bench/spi_master_tb.sv
/* Testbench for spi_master_top. Reads bench/spi_trace.txt from the project
   root. Slave model reacts one sclk after each spi_clk edge, so trace lines
   need clk_div of at least 1. bready and rready are held high. */

`default_nettype none

module spi_master_tb
  import spi_pkg::*;
();

  localparam int TIMEOUT   = 4000;
  localparam int BURST_LEN = QUEUE_DEPTH + 2;

  logic              sclk;
  logic              arst_n;
  axil_req_t         axil_req;
  axil_rsp_t         axil_rsp;
  logic              spi_clk;
  logic              mosi;
  logic              miso;
  logic [NUM_CS-1:0] cs_n;

  // slave model state
  spi_cfg_t          cur_cfg;
  logic [7:0]        miso_q[$];
  logic [7:0]        cap_q[$];
  logic [7:0]        miso_sr;
  logic [7:0]        cap_sr;
  logic              prev_clk;
  logic              prev_active;
  logic              active;
  int                edge_idx;
  int                cap_bits;

  // burst group collected from the trace
  spi_cfg_t          burst_cfg;
  logic [7:0]        burst_tx[$];
  logic [7:0]        burst_miso[$];

  int                seed = 32'h5206_717d;
  int                frames_checked;

  initial sclk = 1'b0;
  always #10 sclk = ~sclk;

  spi_master_top DUT (
    .sclk     (sclk),
    .arst_n   (arst_n),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .spi_clk  (spi_clk),
    .mosi     (mosi),
    .cs_n     (cs_n),
    .miso     (miso)
  );

  // --------------------------------------------------------------------------
  // failure reporting and compares
  // --------------------------------------------------------------------------
  task automatic report_failure();
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic fail_plain(input string msg);
    $display("%s", msg);
    report_failure();
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_rx(input spi_rx_t got, input spi_rx_t exp);
    check_byte("rx.data", got.data, exp.data);
    if (got.cs_sel !== exp.cs_sel) begin
      $display("[ERROR] %0t rx.cs_sel: got %h, expected %h", $time, got.cs_sel, exp.cs_sel);
      report_failure();
    end
  endtask

  task automatic check_cfg(input spi_cfg_t got, input spi_cfg_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ctrl: got %h, expected %h", $time, got, exp);
      report_failure();
    end
  endtask

  // ctrl layout: cpol bit 0, cpha bit 1, clk_div byte 1, cs_sel byte 2
  function automatic logic [31:0] ctrl_word(input spi_cfg_t cfg);
    logic [31:0] w;
    w = '0;
    w[0]      = cfg.cpol;
    w[1]      = cfg.cpha;
    w[15:8]   = cfg.clk_div;
    w[16 +: CS_SEL_BITS] = cfg.cs_sel;
    return w;
  endfunction

  function automatic logic [NUM_CS-1:0] cs_pattern(input logic [CS_SEL_BITS-1:0] sel);
    logic [NUM_CS-1:0] p;
    p      = '1;
    p[sel] = 1'b0;
    return p;
  endfunction

  // --------------------------------------------------------------------------
  // AXI4-Lite host
  // --------------------------------------------------------------------------
  task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    int n;
    n = 0;
    axil_req.awvalid <= 1'b1;
    axil_req.awaddr  <= addr;
    axil_req.wvalid  <= 1'b1;
    axil_req.wdata   <= data;
    axil_req.wstrb   <= 4'hf;
    do begin
      @(posedge sclk);
      n++;
      if (n > TIMEOUT) fail_plain("write address and data never accepted");
    end while (!axil_rsp.awready);
    // address and data are taken in the same cycle
    check_flag("wready", axil_rsp.wready, 1'b1);
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    n = 0;
    do begin
      @(posedge sclk);
      n++;
      if (n > TIMEOUT) fail_plain("write response never arrived");
    end while (!axil_rsp.bvalid);
    resp = axil_rsp.bresp;
  endtask

  task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    int n;
    n = 0;
    axil_req.arvalid <= 1'b1;
    axil_req.araddr  <= addr;
    do begin
      @(posedge sclk);
      n++;
      if (n > TIMEOUT) fail_plain("read address never accepted");
    end while (!axil_rsp.arready);
    axil_req.arvalid <= 1'b0;
    n = 0;
    do begin
      @(posedge sclk);
      n++;
      if (n > TIMEOUT) fail_plain("read data never arrived");
    end while (!axil_rsp.rvalid);
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
  endtask

  // poll STATUS until a flag is set
  task automatic wait_status(input int bitpos, output logic [31:0] word);
    int         n;
    logic [1:0] r;
    n = 0;
    do begin
      axil_read(REG_STATUS, word, r);
      check_resp("rresp STATUS", r, RESP_OKAY);
      n++;
      if (n > TIMEOUT) fail_plain("STATUS flag never set");
    end while (!word[bitpos]);
  endtask

  task automatic wait_capture(output logic [7:0] b);
    int n;
    n = 0;
    while (cap_q.size() == 0) begin
      @(posedge sclk);
      n++;
      if (n > TIMEOUT) fail_plain("slave model captured no byte");
    end
    b = cap_q.pop_front();
  endtask

  // --------------------------------------------------------------------------
  // SPI slave model
  // --------------------------------------------------------------------------
  always @(posedge sclk) begin
    if (arst_n) begin
      active = (cs_n != '1);
      if (active && !prev_active) begin
        // frame start, clock must sit at idle level
        if (cs_n !== cs_pattern(cur_cfg.cs_sel)) fail_plain("wrong cs_n line selected");
        if (spi_clk !== cur_cfg.cpol) fail_plain("spi_clk not at cpol before frame");
        if (miso_q.size() == 0) fail_plain("frame started with no miso byte queued");
        miso_sr  = miso_q.pop_front();
        edge_idx = 0;
        cap_bits = 0;
        // cpha 0 puts the msb out before the first edge
        if (!cur_cfg.cpha) begin
          miso    <= miso_sr[7];
          miso_sr = {miso_sr[6:0], 1'b0};
        end
      end else if (active && (spi_clk !== prev_clk)) begin
        if (cs_n !== cs_pattern(cur_cfg.cs_sel)) fail_plain("cs_n changed during frame");
        if (edge_idx[0] == cur_cfg.cpha) begin
          cap_sr = {cap_sr[6:0], mosi};
          cap_bits++;
          if (cap_bits == 8) cap_q.push_back(cap_sr);
        end else begin
          miso    <= miso_sr[7];
          miso_sr = {miso_sr[6:0], 1'b0};
        end
        edge_idx++;
      end else if (!active && prev_active) begin
        if (spi_clk !== cur_cfg.cpol) fail_plain("spi_clk not at cpol after frame");
        if (edge_idx != 16) fail_plain("frame did not have 16 clock edges");
      end
      prev_active = active;
      prev_clk    = spi_clk;
    end
  end

  // --------------------------------------------------------------------------
  // test sequences
  // --------------------------------------------------------------------------
  task automatic run_single(input spi_cfg_t cfg, input logic [7:0] tx, input logic [7:0] mx);
    logic [1:0]  r;
    logic [31:0] w;
    logic [7:0]  b;
    spi_rx_t     got;
    spi_rx_t     exp;
    axil_write(REG_CTRL, ctrl_word(cfg), r);
    check_resp("bresp CTRL", r, RESP_OKAY);
    cur_cfg = cfg;
    miso_q.push_back(mx);
    axil_write(REG_TXDATA, {24'h0, tx}, r);
    check_resp("bresp TXDATA", r, RESP_OKAY);
    // frame still in setup when this read lands
    axil_read(REG_STATUS, w, r);
    check_resp("rresp STATUS", r, RESP_OKAY);
    check_flag("STATUS.busy", w[STAT_BUSY_BIT], 1'b1);
    wait_status(STAT_RXV_BIT, w);
    // engine idle and queue empty once the byte is back
    check_flag("STATUS.busy after frame", w[STAT_BUSY_BIT], 1'b0);
    axil_read(REG_RXDATA, w, r);
    check_resp("rresp RXDATA", r, RESP_OKAY);
    got.data   = w[7:0];
    got.cs_sel = w[16 +: CS_SEL_BITS];
    exp.data   = mx;
    exp.cs_sel = cfg.cs_sel;
    check_rx(got, exp);
    wait_capture(b);
    check_byte("mosi capture", b, tx);
    frames_checked++;
  endtask

  // queue overflow, OKAY prefix then SLVERR
  task automatic run_burst();
    logic [1:0]  r;
    logic [31:0] w;
    logic [7:0]  b;
    logic [7:0]  exp_q[$];
    logic        seen_err;
    axil_write(REG_CTRL, ctrl_word(burst_cfg), r);
    check_resp("bresp CTRL", r, RESP_OKAY);
    cur_cfg  = burst_cfg;
    seen_err = 1'b0;
    for (int i = 0; i < BURST_LEN; i++) begin
      miso_q.push_back(burst_miso[i]);
      axil_write(REG_TXDATA, {24'h0, burst_tx[i]}, r);
      if (r == RESP_SLVERR) begin
        // the queue alone holds QUEUE_DEPTH frames
        if (i < QUEUE_DEPTH) check_resp("bresp burst TXDATA", r, RESP_OKAY);
        // dropped frame never reaches the slave
        void'(miso_q.pop_back());
        seen_err = 1'b1;
      end else begin
        check_resp("bresp burst TXDATA", r, seen_err ? RESP_SLVERR : RESP_OKAY);
        exp_q.push_back(burst_tx[i]);
      end
    end
    if (!seen_err) fail_plain("burst into a full queue never got SLVERR");
    foreach (exp_q[i]) begin
      wait_capture(b);
      check_byte("burst mosi capture", b, exp_q[i]);
      frames_checked++;
    end
    // drain leftover receive state
    wait_status(STAT_RXV_BIT, w);
    axil_read(REG_RXDATA, w, r);
    axil_read(REG_STATUS, w, r);
  endtask

  task automatic run_overrun();
    logic [1:0]  r;
    logic [31:0] w;
    logic [7:0]  b;
    spi_cfg_t    cfg;
    spi_rx_t     got;
    spi_rx_t     exp;
    cfg.cpol    = 1'b0;
    cfg.cpha    = 1'b1;
    cfg.clk_div = 8'd1;
    cfg.cs_sel  = 2'd3;
    axil_write(REG_CTRL, ctrl_word(cfg), r);
    cur_cfg = cfg;
    miso_q.push_back(8'h3c);
    miso_q.push_back(8'hd2);
    axil_write(REG_TXDATA, 32'h0000_0071, r);
    check_resp("bresp TXDATA", r, RESP_OKAY);
    axil_write(REG_TXDATA, 32'h0000_008e, r);
    check_resp("bresp TXDATA", r, RESP_OKAY);
    wait_status(STAT_OVR_BIT, w);
    check_flag("STATUS.rx_valid", w[STAT_RXV_BIT], 1'b1);
    axil_read(REG_STATUS, w, r);
    check_flag("STATUS.rx_overrun after read", w[STAT_OVR_BIT], 1'b0);
    axil_read(REG_RXDATA, w, r);
    got.data   = w[7:0];
    got.cs_sel = w[16 +: CS_SEL_BITS];
    exp.data   = 8'hd2;
    exp.cs_sel = cfg.cs_sel;
    check_rx(got, exp);
    wait_capture(b);
    check_byte("mosi capture", b, 8'h71);
    wait_capture(b);
    check_byte("mosi capture", b, 8'h8e);
  endtask

  task automatic run_regs();
    logic [1:0]  r;
    logic [31:0] w;
    spi_cfg_t    cfg;
    spi_cfg_t    got;
    axil_read(4'h3, w, r);
    check_resp("rresp unmapped", r, RESP_SLVERR);
    cfg.cpol    = 1'b1;
    cfg.cpha    = 1'b0;
    cfg.clk_div = 8'h5a;
    cfg.cs_sel  = 2'd2;
    axil_write(REG_CTRL, ctrl_word(cfg), r);
    check_resp("bresp CTRL", r, RESP_OKAY);
    axil_read(REG_CTRL, w, r);
    check_resp("rresp CTRL", r, RESP_OKAY);
    got.cpol    = w[0];
    got.cpha    = w[1];
    got.clk_div = w[15:8];
    got.cs_sel  = w[16 +: CS_SEL_BITS];
    check_cfg(got, cfg);
  endtask

  // --------------------------------------------------------------------------
  // main
  // --------------------------------------------------------------------------
  initial begin
    int       fd;
    int       n;
    int       gap;
    string    line;
    int       f_burst, f_cpol, f_cpha, f_div, f_cs, f_tx, f_miso;
    spi_cfg_t cfg;
    arst_n          = 1'b0;
    axil_req        = '0;
    axil_req.bready = 1'b1;
    axil_req.rready = 1'b1;
    miso            = 1'b0;
    cur_cfg         = '0;
    prev_clk        = 1'b0;
    prev_active     = 1'b0;
    frames_checked  = 0;
    repeat (8) @(posedge sclk);
    arst_n <= 1'b1;
    @(posedge sclk);

    fd = $fopen("bench/spi_trace.txt", "r");
    if (fd == 0) fail_plain("cannot open bench/spi_trace.txt");
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n == 0 || line.len() == 0 || line.getc(0) == "#") continue;
      n = $sscanf(line, "%h %h %h %h %h %h %h",
                  f_burst, f_cpol, f_cpha, f_div, f_cs, f_tx, f_miso);
      if (n != 7) continue;
      cfg.cpol    = f_cpol[0];
      cfg.cpha    = f_cpha[0];
      cfg.clk_div = f_div[7:0];
      cfg.cs_sel  = f_cs[CS_SEL_BITS-1:0];
      if (f_burst != 0) begin
        if (burst_tx.size() == 0) burst_cfg = cfg;
        burst_tx.push_back(f_tx[7:0]);
        burst_miso.push_back(f_miso[7:0]);
        if (burst_tx.size() == BURST_LEN) begin
          run_burst();
          burst_tx.delete();
          burst_miso.delete();
        end
      end else begin
        run_single(cfg, f_tx[7:0], f_miso[7:0]);
        gap = {$random(seed)} % 4;
        repeat (gap) @(posedge sclk);
      end
    end
    $fclose(fd);
    if (burst_tx.size() != 0) fail_plain("trace ends inside a burst group");

    run_overrun();
    run_regs();

    if (frames_checked > 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("no transfers were checked");
      report_failure();
    end
  end

endmodule

`default_nettype wire

// File: bench/spi_trace.txt
# burst cpol cpha clk_div cs_sel tx miso, all hex
# burst=1 lines form one back-to-back group of QUEUE_DEPTH+2 writes
0 0 0 01 0 a5 5a
0 0 0 02 1 3c c3
0 0 0 03 2 ff 00
0 0 0 01 3 81 7e
0 0 0 02 0 00 ff
0 0 1 01 1 96 69
0 0 1 03 2 12 34
0 0 1 02 3 fe 01
0 0 1 01 0 55 aa
0 0 1 02 2 c8 8c
0 1 0 01 2 e7 18
0 1 0 02 3 42 24
0 1 0 03 0 0f f0
0 1 0 01 1 b4 4b
0 1 0 02 2 6d d6
0 1 1 01 3 77 88
0 1 1 02 0 a0 05
0 1 1 03 1 19 91
0 1 1 01 2 f3 3f
0 1 1 02 1 5e e5
1 1 1 01 2 11 e1
1 1 1 01 2 22 d2
1 1 1 01 2 33 c3
1 1 1 01 2 44 b4
1 1 1 01 2 55 a5
1 1 1 01 2 66 96

// File: compile.f
hw/spi_pkg.sv
hw/spi_axil_regs.sv
hw/spi_cmd_queue.sv
hw/spi_shift_engine.sv
hw/spi_master_top.sv
bench/spi_master_checker.sv
bench/spi_master_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the SPI master testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f \
  --top-module spi_master_tb

out="$(./obj_dir/Vspi_master_tb)"
echo "$out"

if echo "$out" | grep -q "all tests passed"; then
  exit 0
else
  exit 1
fi
